//--- fpu_cfg.svh
// Build-time configuration of the FP32 non-computational unit
// Operand width, transaction tag width and result pipeline depth

`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// Operand and result width, scalar FP32 only
`define FPU_FLEN 32

// Transaction id carried alongside each request
`define FPU_TAG_BITS 3

// Number of registered result stages, at least 1
`define FPU_PIPE_DEPTH 2

`endif

//--- fpu_pkg.sv
// Shared types of the FPU wrapper
// Vector typedefs, opcode and unit operation enums, request and response structs

`include "fpu_cfg.svh"

package fpu_pkg;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    typedef logic [`FPU_FLEN-1:0]     fpu_operand_t;  // Operand or result
    typedef logic [`FPU_TAG_BITS-1:0] fpu_tag_t;      // Transaction id
    typedef logic [2:0]               fpu_rm_t;       // rm field / sub-operation
    typedef logic [4:0]               fpu_status_t;   // NV, DZ, OF, UF, NX

    // Quiet NaN returned when both min/max inputs are NaN
    localparam fpu_operand_t CANONICAL_NAN = 32'h7fc0_0000;

    // ------------------------------------------------------------
    // Operation encodings
    // ------------------------------------------------------------
    // Opcodes as issued by the core
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,
        FMIN_MAX = 3'd1,
        FCMP     = 3'd2,
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,
        FMV_X2F  = 3'd5
    } fpu_opcode_e;

    // Operation groups of the execution unit
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } fpu_unit_op_e;

    // Upstream protocol inversion FSM
    typedef enum logic {
        READY = 1'b0,
        STALL = 1'b1
    } fpu_issue_state_e;

    // ------------------------------------------------------------
    // Transaction structs
    // ------------------------------------------------------------
    typedef struct packed {
        fpu_operand_t operand_a;
        fpu_operand_t operand_b;
        fpu_unit_op_e op;
        fpu_rm_t      rm;   // Sub-operation select
        fpu_tag_t     tag;
    } fpu_req_t;

    typedef struct packed {
        fpu_operand_t result;
        fpu_status_t  status;
        fpu_tag_t     tag;
    } fpu_rsp_t;

endpackage

//--- fpu_op_decode.sv
// Opcode translation for the FPU wrapper
// Maps a core opcode and rm field onto a unit operation and sub-operation

`timescale 1ns/1ps

module fpu_op_decode (
    input  fpu_pkg::fpu_opcode_e  opcode_i,
    input  fpu_pkg::fpu_rm_t      rm_i,
    input  fpu_pkg::fpu_operand_t operand_a_i,
    input  fpu_pkg::fpu_operand_t operand_b_i,
    input  fpu_pkg::fpu_tag_t     trans_id_i,
    output fpu_pkg::fpu_req_t     req_o
);

    // ------------------------------------------------------------
    // Input translation
    // ------------------------------------------------------------
    always_comb begin : p_translate
        // Operands and tag pass straight through
        req_o.operand_a = operand_a_i;
        req_o.operand_b = operand_b_i;
        req_o.tag       = trans_id_i;
        req_o.op        = fpu_pkg::SGNJ;        // Sign injection by default
        req_o.rm        = {1'b0, rm_i[1:0]};    // MSB is the alt-half bit, unused here

        unique case (opcode_i)
            // Variant in rm: 000 sgnj, 001 sgnjn, 010 sgnjx
            fpu_pkg::FSGNJ:    req_o.op = fpu_pkg::SGNJ;
            // Variant in rm: 000 min, 001 max
            fpu_pkg::FMIN_MAX: req_o.op = fpu_pkg::MINMAX;
            // Variant in rm: 000 le, 001 lt, 010 eq
            fpu_pkg::FCMP:     req_o.op = fpu_pkg::CMP;
            fpu_pkg::FCLASS:   req_o.op = fpu_pkg::CLASSIFY;   // rm ignored

            // Register moves need no recoding at FLEN 32
            fpu_pkg::FMV_F2X,
            fpu_pkg::FMV_X2F: begin
                req_o.op = fpu_pkg::SGNJ;
                req_o.rm = 3'b011;              // Passthrough of operand a
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // Encodings 6 and 7 have no meaning; an undriven bus before
    // start-up is tolerated
    always_comb begin : p_opcode_chk
        a_opcode_known : assert final ($isunknown(opcode_i) ||
                                       opcode_i inside {fpu_pkg::FSGNJ,
                                                        fpu_pkg::FMIN_MAX,
                                                        fpu_pkg::FCMP,
                                                        fpu_pkg::FCLASS,
                                                        fpu_pkg::FMV_F2X,
                                                        fpu_pkg::FMV_X2F})
        else $error("fpu_op_decode: undefined opcode %0d", opcode_i);
    end

endmodule

//--- fpu_issue_buffer.sv
// Upstream protocol inversion for the FPU wrapper
// READY/STALL FSM, hold register and request select towards the unit

`timescale 1ns/1ps

module fpu_issue_buffer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              valid_i,       // Request from issue
    input  fpu_pkg::fpu_req_t req_i,
    output logic              ready_o,       // Token back to issue
    output logic              unit_valid_o,
    output fpu_pkg::fpu_req_t unit_req_o,
    input  logic              unit_ready_i
);

    fpu_pkg::fpu_issue_state_e state_q, state_d;
    fpu_pkg::fpu_req_t         hold_q;       // Request parked while stalling
    logic                      hold_en;      // Capture into hold register
    logic                      use_hold;     // Unit sees the held request

    // ------------------------------------------------------------
    // Protocol FSM
    // ------------------------------------------------------------
    always_comb begin : p_issue_fsm
        ready_o      = 1'b0;
        unit_valid_o = 1'b0;
        hold_en      = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        unique case (state_q)
            fpu_pkg::READY: begin
                ready_o      = 1'b1;         // Act as if always ready
                unit_valid_o = valid_i;      // Forward directly
                // Unit busy, so park the request and stop issue
                if (valid_i && !unit_ready_i) begin
                    ready_o = 1'b0;
                    hold_en = 1'b1;
                    state_d = fpu_pkg::STALL;
                end
            end
            fpu_pkg::STALL: begin
                unit_valid_o = 1'b1;         // Held request is pending
                use_hold     = 1'b1;
                if (unit_ready_i) begin
                    ready_o = 1'b1;          // Held request consumed
                    // A request taken with this token is parked for next cycle
                    if (valid_i) begin
                        hold_en = 1'b1;
                    end else begin
                        state_d = fpu_pkg::READY;
                    end
                end
            end
            default: ;
        endcase

        // Flush overrides everything and returns to idle
        if (flush_i) begin
            state_d = fpu_pkg::READY;
        end
    end

    // ------------------------------------------------------------
    // State and hold register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= fpu_pkg::READY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin : p_hold
        if (hold_en) begin
            hold_q <= req_i;
        end
    end

    // Held request wins while stalling, else the live one
    assign unit_req_o = use_hold ? hold_q : req_i;

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // An offered request is never withdrawn before the unit takes it
    a_valid_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (unit_valid_o && !unit_ready_i && !flush_i) |=> unit_valid_o)
    else $error("fpu_issue_buffer: request withdrawn while stalled");

    // Parked request reaches the unit unchanged for the whole stall
    a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (unit_valid_o && !unit_ready_i && !flush_i) |=> unit_req_o == $past(unit_req_o))
    else $error("fpu_issue_buffer: request changed while stalled");

endmodule

//--- fpu_noncomp_calc.sv
// Non-computational FP32 operations
// Sign injection, min/max, compare and classify, purely combinational
// NV is the only status flag these operations can raise

`timescale 1ns/1ps

module fpu_noncomp_calc (
    input  fpu_pkg::fpu_req_t req_i,
    output fpu_pkg::fpu_rsp_t rsp_o
);

    // RISC-V class of one FP32 value, one-hot
    // 0 -inf, 1 -norm, 2 -sub, 3 -0, 4 +0, 5 +sub, 6 +norm, 7 +inf, 8 sNaN, 9 qNaN
    function automatic logic [9:0] fp_class(input fpu_pkg::fpu_operand_t x);
        logic       sgn;
        logic       exp_max;
        logic       exp_zero;
        logic       man_zero;
        logic [9:0] cls;
        sgn      = x[31];
        exp_max  = &x[30:23];
        exp_zero = ~|x[30:23];
        man_zero = ~|x[22:0];
        cls      = '0;
        if (exp_max && !man_zero) begin
            if (x[22]) cls[9] = 1'b1;               // Quiet bit set
            else       cls[8] = 1'b1;
        end else if (exp_max) begin
            if (sgn) cls[0] = 1'b1;
            else     cls[7] = 1'b1;
        end else if (exp_zero && man_zero) begin
            if (sgn) cls[3] = 1'b1;
            else     cls[4] = 1'b1;
        end else if (exp_zero) begin
            if (sgn) cls[2] = 1'b1;
            else     cls[5] = 1'b1;
        end else begin
            if (sgn) cls[1] = 1'b1;
            else     cls[6] = 1'b1;
        end
        return cls;
    endfunction

    fpu_pkg::fpu_operand_t a, b;
    logic [9:0] cls_a, cls_b;
    logic       a_nan, b_nan, any_nan, any_snan;
    logic       both_zero;
    logic       a_lt_b;      // Sign-magnitude order, -0 below +0
    logic       cmp_lt, cmp_eq;
    logic       nv;

    assign a     = req_i.operand_a;
    assign b     = req_i.operand_b;
    assign cls_a = fp_class(a);
    assign cls_b = fp_class(b);

    // ------------------------------------------------------------
    // Operand properties and ordering
    // ------------------------------------------------------------
    assign a_nan     = cls_a[8] | cls_a[9];
    assign b_nan     = cls_b[8] | cls_b[9];
    assign any_nan   = a_nan | b_nan;
    assign any_snan  = cls_a[8] | cls_b[8];
    assign both_zero = (cls_a[3] | cls_a[4]) & (cls_b[3] | cls_b[4]);

    always_comb begin : p_order
        if (a[31] != b[31]) begin
            a_lt_b = a[31];                         // Negative one is smaller
        end else if (a[31]) begin
            a_lt_b = a[30:0] > b[30:0];             // Both negative, larger magnitude loses
        end else begin
            a_lt_b = a[30:0] < b[30:0];
        end
    end

    // Compare treats the two zeros as equal
    assign cmp_lt = a_lt_b & ~both_zero;
    assign cmp_eq = (a == b) | both_zero;

    // ------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------
    always_comb begin : p_result
        rsp_o.result = a;
        nv           = 1'b0;

        unique case (req_i.op)
            fpu_pkg::SGNJ: begin
                unique case (req_i.rm)
                    3'b000:  rsp_o.result = {b[31], a[30:0]};
                    3'b001:  rsp_o.result = {~b[31], a[30:0]};
                    3'b010:  rsp_o.result = {a[31] ^ b[31], a[30:0]};
                    default: rsp_o.result = a;            // 011 passthrough for moves
                endcase
            end
            fpu_pkg::MINMAX: begin
                nv = any_snan;
                if (a_nan && b_nan) begin
                    rsp_o.result = fpu_pkg::CANONICAL_NAN;
                end else if (a_nan) begin
                    rsp_o.result = b;
                end else if (b_nan) begin
                    rsp_o.result = a;
                end else if (req_i.rm[0]) begin
                    rsp_o.result = a_lt_b ? b : a;        // max
                end else begin
                    rsp_o.result = a_lt_b ? a : b;        // min
                end
            end
            fpu_pkg::CMP: begin
                rsp_o.result = '0;
                unique case (req_i.rm)
                    3'b000: begin                         // le, signaling
                        nv              = any_nan;
                        rsp_o.result[0] = ~any_nan & (cmp_lt | cmp_eq);
                    end
                    3'b001: begin                         // lt, signaling
                        nv              = any_nan;
                        rsp_o.result[0] = ~any_nan & cmp_lt;
                    end
                    3'b010: begin                         // eq, quiet
                        nv              = any_snan;
                        rsp_o.result[0] = ~any_nan & cmp_eq;
                    end
                    default: ;
                endcase
            end
            fpu_pkg::CLASSIFY: rsp_o.result = {22'b0, cls_a};
            default: ;
        endcase
    end

    assign rsp_o.status = {nv, 4'b0000};    // NV sits in the MSB
    assign rsp_o.tag    = req_i.tag;

endmodule

//--- fpu_noncomp_pipe.sv
// Result pipeline of the non-computational unit
// Computes at entry and shifts responses through stall-able stages

`timescale 1ns/1ps

`include "fpu_cfg.svh"

module fpu_noncomp_pipe (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              in_valid_i,
    input  fpu_pkg::fpu_req_t req_i,
    output logic              in_ready_o,
    output logic              out_valid_o,
    output fpu_pkg::fpu_rsp_t rsp_o,
    input  logic              out_ready_i
);

    localparam int unsigned DEPTH = `FPU_PIPE_DEPTH;

    fpu_pkg::fpu_rsp_t calc_rsp;                // Response of the entering request
    fpu_pkg::fpu_rsp_t rsp_q [DEPTH];
    logic [DEPTH-1:0]  valid_q;
    logic              advance;                 // All stages shift together

    fpu_noncomp_calc u_calc (
        .req_i (req_i),
        .rsp_o (calc_rsp)
    );

    // Move when the sink takes the output or the last slot is a bubble
    assign advance    = out_ready_i | ~valid_q[DEPTH-1];
    assign in_ready_o = advance;

    // ------------------------------------------------------------
    // Stage registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;                      // Drop everything in flight
        end else if (advance) begin
            valid_q[0] <= in_valid_i;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin : p_payload
        if (advance) begin
            rsp_q[0] <= calc_rsp;
            for (int i = 1; i < DEPTH; i++) begin
                rsp_q[i] <= rsp_q[i-1];
            end
        end
    end

    assign out_valid_o = valid_q[DEPTH-1];
    assign rsp_o       = rsp_q[DEPTH-1];

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // A stalled response stays put until the sink takes it
    a_out_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (out_valid_o && !out_ready_i && !flush_i) |=> out_valid_o && $stable(rsp_o))
    else $error("fpu_noncomp_pipe: response changed under back-pressure");

endmodule

//--- fpu_wrap.sv
// Top level of the FP32 non-computational FPU wrapper
// Opcode decode, upstream protocol inversion and the result pipeline

`timescale 1ns/1ps

module fpu_wrap (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    // Issue side
    input  logic                  fpu_valid_i,
    output logic                  fpu_ready_o,
    input  fpu_pkg::fpu_opcode_e  opcode_i,
    input  fpu_pkg::fpu_rm_t      rm_i,
    input  fpu_pkg::fpu_operand_t operand_a_i,
    input  fpu_pkg::fpu_operand_t operand_b_i,
    input  fpu_pkg::fpu_tag_t     trans_id_i,
    // Writeback side
    output logic                  fpu_valid_o,
    output fpu_pkg::fpu_rsp_t     rsp_o,
    input  logic                  wb_ready_i
);

    fpu_pkg::fpu_req_t dec_req;        // Translated request
    fpu_pkg::fpu_req_t unit_req;       // Live or held request
    logic              unit_valid;
    logic              unit_ready;     // Pipeline advance

    fpu_op_decode u_op_decode (
        .opcode_i    (opcode_i),
        .rm_i        (rm_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .req_o       (dec_req)
    );

    fpu_issue_buffer u_issue_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .valid_i      (fpu_valid_i),
        .req_i        (dec_req),
        .ready_o      (fpu_ready_o),
        .unit_valid_o (unit_valid),
        .unit_req_o   (unit_req),
        .unit_ready_i (unit_ready)
    );

    fpu_noncomp_pipe u_noncomp_pipe (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .in_valid_i  (unit_valid),
        .req_i       (unit_req),
        .in_ready_o  (unit_ready),
        .out_valid_o (fpu_valid_o),
        .rsp_o       (rsp_o),
        .out_ready_i (wb_ready_i)
    );

endmodule

//--- tb_fpu_wrap.sv
// Self-checking testbench of the FP32 non-computational FPU wrapper
// Stimulus and expected responses come from the test data file
// Random valid gaps, random back-pressure and a flush in flight

`timescale 1ns/1ps

module tb_fpu_wrap;

    localparam int FIELDS          = 7;     // Words per transaction line
    localparam int MAX_VECS        = 64;
    localparam int ACCEPT_TIMEOUT  = 100;   // Cycles
    localparam int DRAIN_TIMEOUT   = 300;
    localparam int POST_FLUSH_VECS = 8;     // Vectors 3 onwards sent after the flush

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  flush_i;
    logic                  fpu_valid_i;
    logic                  fpu_ready_o;
    fpu_pkg::fpu_opcode_e  opcode_i;
    fpu_pkg::fpu_rm_t      rm_i;
    fpu_pkg::fpu_operand_t operand_a_i;
    fpu_pkg::fpu_operand_t operand_b_i;
    fpu_pkg::fpu_tag_t     trans_id_i;
    logic                  fpu_valid_o;
    fpu_pkg::fpu_rsp_t     rsp_o;
    logic                  wb_ready_i;

    logic [31:0]       vec_mem [0:MAX_VECS*FIELDS-1];
    int                n_vec;
    fpu_pkg::fpu_rsp_t exp_q [$];            // Expected responses in issue order
    logic [31:0]       rng_state = 32'h556f_711e;
    int                rsp_count   = 0;
    int                stall_count = 0;      // Requests parked by the issue side
    logic              hold_back   = 1'b0;   // Forces wb_ready_i low
    logic              stalled_q;            // Shadow of the issue FSM
    logic              accept;

    fpu_wrap u_fpu_wrap (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .fpu_valid_i (fpu_valid_i),
        .fpu_ready_o (fpu_ready_o),
        .opcode_i    (opcode_i),
        .rm_i        (rm_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .fpu_valid_o (fpu_valid_o),
        .rsp_o       (rsp_o),
        .wb_ready_i  (wb_ready_i)
    );

    always #20 clk_i = ~clk_i;              // 40 ns period

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_result(input fpu_pkg::fpu_operand_t got,
                                input fpu_pkg::fpu_operand_t exp,
                                input fpu_pkg::fpu_tag_t     tag);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t ns: result %h for tag %0d, expected %h",
                                     $time, got, tag, exp));
        end
    endtask

    task automatic verify_status(input fpu_pkg::fpu_status_t got,
                                 input fpu_pkg::fpu_status_t exp,
                                 input fpu_pkg::fpu_tag_t    tag);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t ns: flags %b for tag %0d, expected %b",
                                     $time, got, tag, exp));
        end
    endtask

    task automatic match_tag(input fpu_pkg::fpu_tag_t got, input fpu_pkg::fpu_tag_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t ns: response tag %0d, expected %0d",
                                     $time, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // Upstream handshake tracking
    // ------------------------------------------------------------
    // A request is taken in READY even when ready drops, in STALL only with ready
    assign accept = fpu_valid_i && (fpu_ready_o || !stalled_q);

    always @(posedge clk_i or negedge rst_ni) begin : p_stall_track
        if (!rst_ni) begin
            stalled_q <= 1'b0;
        end else if (flush_i) begin
            stalled_q <= 1'b0;
        end else if (stalled_q) begin
            stalled_q <= fpu_valid_i || !fpu_ready_o;   // Leaves once drained
        end else begin
            stalled_q <= fpu_valid_i && !fpu_ready_o;   // Request parked
            if (fpu_valid_i && !fpu_ready_o) begin
                stall_count++;
            end
        end
    end

    // Sends vector idx, entered and left at a falling edge
    task automatic send_request(input int idx, input bit use_gap);
        int gap;
        int cycles;
        int base;
        fpu_pkg::fpu_rsp_t exp;
        base = idx * FIELDS;
        gap  = use_gap ? int'(next_random() % 4) : 0;
        @(posedge clk_i);
        #2;
        if (gap != 0) begin
            fpu_valid_i = 1'b0;
            repeat (gap) @(posedge clk_i);
            #2;
        end
        opcode_i    = fpu_pkg::fpu_opcode_e'(vec_mem[base][2:0]);
        rm_i        = vec_mem[base+1][2:0];
        operand_a_i = vec_mem[base+2];
        operand_b_i = vec_mem[base+3];
        trans_id_i  = vec_mem[base+4][2:0];
        fpu_valid_i = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!accept && cycles < ACCEPT_TIMEOUT);
        if (!accept) begin
            report_failure($sformatf("Timeout: request %0d was never accepted", idx));
        end
        exp.result = vec_mem[base+5];
        exp.status = vec_mem[base+6][4:0];
        exp.tag    = vec_mem[base+4][2:0];
        exp_q.push_back(exp);
    endtask

    task automatic drain_wait();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            report_failure($sformatf("Timeout: %0d responses still missing", exp_q.size()));
        end
        @(negedge clk_i);
    endtask

    // ------------------------------------------------------------
    // Back-pressure and response monitor
    // ------------------------------------------------------------
    always @(posedge clk_i) begin : p_backpressure
        #2;
        if (hold_back) begin
            wb_ready_i = 1'b0;
        end else begin
            wb_ready_i = (next_random() % 8) < 5;   // Ready about 5 of 8 cycles
        end
    end

    always @(negedge clk_i) begin : p_monitor
        fpu_pkg::fpu_rsp_t exp_rsp;
        if (rst_ni && fpu_valid_o && wb_ready_i) begin
            if (exp_q.size() == 0) begin
                report_failure($sformatf("Response with tag %0d arrived with nothing pending",
                                         rsp_o.tag));
            end else begin
                exp_rsp = exp_q.pop_front();
                match_tag(rsp_o.tag, exp_rsp.tag);
                check_result(rsp_o.result, exp_rsp.result, exp_rsp.tag);
                verify_status(rsp_o.status, exp_rsp.status, exp_rsp.tag);
                rsp_count++;
            end
        end
        // In-flight work is dropped at the flush edge
        if (rst_ni && flush_i) begin
            exp_q.delete();
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin : p_main
        int i;
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        fpu_valid_i = 1'b0;
        opcode_i    = fpu_pkg::FSGNJ;
        rm_i        = '0;
        operand_a_i = '0;
        operand_b_i = '0;
        trans_id_i  = '0;
        wb_ready_i  = 1'b0;

        $readmemh("fpu_testdata.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VECS && !$isunknown(vec_mem[n_vec*FIELDS])) begin
            n_vec++;
        end
        if (n_vec < 3 + POST_FLUSH_VECS) begin
            report_failure("Test data file is missing or holds too few transactions");
        end

        repeat (16) @(posedge clk_i);
        #2 rst_ni = 1'b1;
        @(negedge clk_i);

        // All vectors under random gaps and back-pressure
        for (i = 0; i < n_vec; i++) begin
            send_request(i, 1'b1);
        end
        @(posedge clk_i);
        #2 fpu_valid_i = 1'b0;
        drain_wait();
        if (fpu_ready_o !== 1'b1) begin
            report_failure("fpu_ready_o is low after the last response");
        end
        if (stall_count == 0) begin
            report_failure("Random back-pressure never parked a request on the issue side");
        end

        // Fill pipe and hold register, then flush
        hold_back = 1'b1;
        for (i = 0; i < 3; i++) begin
            send_request(i, 1'b0);              // Third one is parked
        end
        @(posedge clk_i);
        #2;
        fpu_valid_i = 1'b0;
        flush_i     = 1'b1;
        @(posedge clk_i);
        #2 flush_i = 1'b0;
        repeat (4) begin
            @(negedge clk_i);
            if (fpu_valid_o !== 1'b0) begin
                report_failure("fpu_valid_o raised after flush with nothing in flight");
            end
            if (fpu_ready_o !== 1'b1) begin
                report_failure("fpu_ready_o is low after flush");
            end
        end

        // Fresh traffic after the flush
        hold_back = 1'b0;
        for (i = 3; i < 3 + POST_FLUSH_VECS; i++) begin
            send_request(i, 1'b1);
        end
        @(posedge clk_i);
        #2 fpu_valid_i = 1'b0;
        drain_wait();

        // Every vector once, plus the fresh ones, and none of the flushed
        if (rsp_count == n_vec + POST_FLUSH_VECS) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- fpu_testdata.txt
// opcode rm operand_a operand_b tag result flags, all hex
// opcode 0 sgnj 1 minmax 2 cmp 3 class 4 mv.f2x 5 mv.x2f, flags 10 is NV
// Sign injection and moves
0 0 3f800000 c0000000 0 bf800000 0
0 1 3f800000 c0000000 1 3f800000 0
0 2 bf800000 c0000000 2 3f800000 0
0 4 40400000 80000000 3 c0400000 0
0 1 7fa00000 00000000 4 ffa00000 0
4 0 c0490fdb 12345678 5 c0490fdb 0
5 2 7fa00000 ffffffff 6 7fa00000 0
// Min and max
1 0 3f800000 40000000 7 3f800000 0
1 1 3f800000 40000000 0 40000000 0
1 0 c0000000 bf800000 1 c0000000 0
1 1 c0000000 bf800000 2 bf800000 0
1 0 80000000 00000000 3 80000000 0
1 1 80000000 00000000 4 00000000 0
1 0 7fc00000 40000000 5 40000000 0
1 1 bf800000 ffc00001 6 bf800000 0
1 0 7fc00000 ffc00001 7 7fc00000 0
1 1 7fa00000 3f800000 0 3f800000 10
1 0 7fa00000 7fc00000 1 7fc00000 10
// Compare, rm 0 le 1 lt 2 eq
2 0 3f800000 40000000 2 00000001 0
2 1 40000000 3f800000 3 00000000 0
2 2 3f800000 3f800000 4 00000001 0
2 0 3f800000 3f800000 5 00000001 0
2 2 80000000 00000000 6 00000001 0
2 1 80000000 00000000 7 00000000 0
2 1 c0000000 bf800000 0 00000001 0
2 2 7fc00000 3f800000 1 00000000 0
2 2 7fa00000 3f800000 2 00000000 10
2 0 3f800000 7fc00000 3 00000000 10
2 1 7fc00000 7fc00000 4 00000000 10
2 6 40400000 40400000 5 00000001 0
// Classify, one line per class bit 0 to 9
3 0 ff800000 00000000 6 00000001 0
3 0 bf800000 00000000 7 00000002 0
3 0 80000001 00000000 0 00000004 0
3 0 80000000 00000000 1 00000008 0
3 0 00000000 00000000 2 00000010 0
3 0 007fffff 00000000 3 00000020 0
3 0 3f800000 00000000 4 00000040 0
3 0 7f800000 00000000 5 00000080 0
3 0 7fa00000 00000000 6 00000100 0
3 0 ffc00000 00000000 7 00000200 0

//--- src.f
+incdir+.
fpu_pkg.sv
fpu_op_decode.sv
fpu_issue_buffer.sv
fpu_noncomp_calc.sv
fpu_noncomp_pipe.sv
fpu_wrap.sv
tb_fpu_wrap.sv
